// File: Makefile
# Verilator build for the 16-point SDF FFT

VERILATOR   ?= verilator
TOP         ?= fft_tb
FILELIST    ?= all.f
BUILD_DIR   ?= obj_dir
VFLAGS      ?= --binary --timing --assert -Wno-fatal
LINT_FLAGS  ?= --lint-only --timing -Wall
EXTRA_FLAGS ?=

SIM := $(BUILD_DIR)/V$(TOP)

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) $(EXTRA_FLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: build
	./$(SIM)

lint:
	$(VERILATOR) $(LINT_FLAGS) $(EXTRA_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR)

// File: all.f
common/fft_pkg.sv
common/sample_stream_if.sv
sdf_pipeline/sdf_stage.sv
sdf_pipeline/twiddle_rotator.sv
hw/fft_top.sv
tb/fft_asserts.sv
tb/fft_tb.sv

// File: common/fft_pkg.sv
package fft_pkg;

	localparam int n_points  = 16;                        // Transform length
	localparam int log2_n    = 4;                         // Number of SDF stages
	localparam int data_w    = 16;                        // External sample part width
	localparam int frac_w    = 4;                         // Guard fraction bits below the input LSB
	localparam int int_w     = data_w + log2_n + frac_w;  // Internal width, 24 bits
	localparam int tw_w      = 16;                        // Twiddle part width
	localparam int tw_frac_w = 14;                        // Twiddle fraction bits, Q2.14

	typedef struct packed {
		logic signed [int_w-1:0] re;   // Real part
		logic signed [int_w-1:0] im;   // Imaginary part
	} cplx_t;

	typedef struct packed {
		logic signed [tw_w-1:0] re;    // cos term
		logic signed [tw_w-1:0] im;    // -sin term
	} twiddle_t;

	// W16^m = cos(2*pi*m/16) - j*sin(2*pi*m/16), scaled by 2^14
	localparam twiddle_t tw_rom [n_points] = '{
		'{ 16'sd16384,  16'sd0     },   // m = 0, unity
		'{ 16'sd15137, -16'sd6270  },   // m = 1
		'{ 16'sd11585, -16'sd11585 },   // m = 2
		'{ 16'sd6270,  -16'sd15137 },   // m = 3
		'{ 16'sd0,     -16'sd16384 },   // m = 4, -j
		'{-16'sd6270,  -16'sd15137 },   // m = 5
		'{-16'sd11585, -16'sd11585 },   // m = 6
		'{-16'sd15137, -16'sd6270  },   // m = 7
		'{-16'sd16384,  16'sd0     },   // m = 8, -1
		'{-16'sd15137,  16'sd6270  },   // m = 9, highest index the 3n pattern reaches
		'{-16'sd11585,  16'sd11585 },   // m = 10
		'{-16'sd6270,   16'sd15137 },   // m = 11
		'{ 16'sd0,      16'sd16384 },   // m = 12, +j
		'{ 16'sd6270,   16'sd15137 },   // m = 13
		'{ 16'sd11585,  16'sd11585 },   // m = 14
		'{ 16'sd15137,  16'sd6270  }    // m = 15
	};

	// What follows a butterfly stage
	typedef enum logic [1:0] {
		rot_none,      // Nothing, last stage of the pipeline
		rot_minus_j,   // Trivial -j on the last quarter of each block
		rot_table      // Full twiddle multiply from tw_rom
	} rot_e;

endpackage

// File: common/sample_stream_if.sv
`timescale 1ns/1ps

// One complex sample stream between two pipeline blocks
// A sample is taken on every rising CLK edge with valid high, no ready
interface sample_stream_if;

	logic                      valid;    // Sample present this cycle
	logic                      last;     // Marks index n_points-1
	fft_pkg::cplx_t            sample;   // Complex payload
	logic [fft_pkg::log2_n-1:0] index;   // Position inside the frame

	modport src (
		output valid, last, sample, index
	);

	modport snk (
		input valid, last, sample, index
	);

endinterface

// File: hw/fft_top.sv
`timescale 1ns/1ps

// 16-point radix-2^2 SDF FFT, results leave in bit-reversed order
module fft_top (
	input  logic                       CLK,
	input  logic                       RST,
	input  logic                       valid_i,
	input  logic [fft_pkg::data_w-1:0] data_re_i,
	input  logic [fft_pkg::data_w-1:0] data_im_i,
	output logic                       valid_o,
	output logic                       last_o,
	output logic [fft_pkg::data_w-1:0] data_re_o,
	output logic [fft_pkg::data_w-1:0] data_im_o
);

	logic [fft_pkg::log2_n-1:0] in_cnt;   // Input sample position in the frame

	sample_stream_if st_in ();            // Widened input
	sample_stream_if st0 ();              // After stage 0, -j applied
	sample_stream_if st1 ();              // After stage 1
	sample_stream_if st_rot ();           // After twiddle multiply
	sample_stream_if st2 ();              // After stage 2, -j applied
	sample_stream_if st3 ();              // Final stream

	always_ff @(posedge CLK or posedge RST)
	begin
		if (RST)
			in_cnt <= '0;
		else if (valid_i)
			in_cnt <= in_cnt + 1'b1;          // Wraps every frame
	end

	// Sign extend into the growth bits, guard bits below the LSB
	assign st_in.valid     = valid_i;
	assign st_in.last      = valid_i & (&in_cnt);
	assign st_in.index     = in_cnt;
	assign st_in.sample.re = {{fft_pkg::log2_n{data_re_i[fft_pkg::data_w-1]}}, data_re_i,
		{fft_pkg::frac_w{1'b0}}};
	assign st_in.sample.im = {{fft_pkg::log2_n{data_im_i[fft_pkg::data_w-1]}}, data_im_i,
		{fft_pkg::frac_w{1'b0}}};

	sdf_stage #(.stage_idx(0)) i_stage0 (.CLK(CLK), .RST(RST), .in_s(st_in), .out_s(st0));
	sdf_stage #(.stage_idx(1)) i_stage1 (.CLK(CLK), .RST(RST), .in_s(st0), .out_s(st1));

	twiddle_rotator i_rotator (.CLK(CLK), .RST(RST), .in_s(st1), .out_s(st_rot));

	sdf_stage #(.stage_idx(2)) i_stage2 (.CLK(CLK), .RST(RST), .in_s(st_rot), .out_s(st2));
	sdf_stage #(.stage_idx(3)) i_stage3 (.CLK(CLK), .RST(RST), .in_s(st2), .out_s(st3));

	// Drop guard and growth bits, result is DFT / n_points
	assign valid_o   = st3.valid;
	assign last_o    = st3.last;
	assign data_re_o = st3.sample.re[fft_pkg::frac_w + fft_pkg::log2_n +: fft_pkg::data_w];
	assign data_im_o = st3.sample.im[fft_pkg::frac_w + fft_pkg::log2_n +: fft_pkg::data_w];

endmodule

// File: sdf_pipeline/sdf_stage.sv
`timescale 1ns/1ps

// Radix-2 SDF butterfly with feedback delay line
module sdf_stage #(
	parameter int stage_idx = 0                  // 0 .. log2_n-1
) (
	input logic             CLK,
	input logic             RST,
	sample_stream_if.snk    in_s,
	sample_stream_if.src    out_s
);

	localparam int dly     = fft_pkg::n_points >> (stage_idx + 1);   // 8, 4, 2, 1
	localparam int sel_bit = fft_pkg::log2_n - 1 - stage_idx;        // Half-block bit of index
	localparam logic [fft_pkg::log2_n-1:0] dly_idx = dly[fft_pkg::log2_n-1:0];

	// Even stages close with -j, stage 1 feeds the twiddle rotator, last stage nothing
	localparam fft_pkg::rot_e rot = (stage_idx % 2 == 0) ? fft_pkg::rot_minus_j :
		(stage_idx == fft_pkg::log2_n - 1) ? fft_pkg::rot_none : fft_pkg::rot_table;

	fft_pkg::cplx_t             line_q [dly];   // Feedback delay line, line_q[0] is oldest
	fft_pkg::cplx_t             head;           // Sample leaving the delay line
	fft_pkg::cplx_t             bf_out;         // Butterfly result towards the output
	fft_pkg::cplx_t             fb;             // Value pushed back into the delay line
	fft_pkg::cplx_t             res;            // Output after optional rotation
	logic [fft_pkg::log2_n-1:0] out_idx;        // Frame position of the outgoing sample
	logic                       hi_half;        // Second half of the block
	logic                       mj_sel;         // Apply -j to this sample

	assign head    = line_q[0];
	assign hi_half = in_s.index[sel_bit];
	assign out_idx = in_s.index - dly_idx;      // Output lags by dly valid samples, wraps mod 16

	// Last quarter of each output block, only where -j follows the stage
	if (rot == fft_pkg::rot_minus_j)
	begin : g_mj
		assign mj_sel = out_idx[sel_bit] & out_idx[sel_bit-1];
	end
	else
	begin : g_no_mj
		assign mj_sel = 1'b0;
	end

	always_comb
	begin
		if (hi_half)
		begin
			bf_out.re = head.re + in_s.sample.re;   // Sum goes downstream
			bf_out.im = head.im + in_s.sample.im;
			fb.re     = head.re - in_s.sample.re;   // Difference waits one half block
			fb.im     = head.im - in_s.sample.im;
		end
		else
		begin
			bf_out = head;                          // Old differences drain out
			fb     = in_s.sample;                   // First half just fills the line
		end
	end

	always_comb
	begin
		if (mj_sel)
		begin
			res.re = bf_out.im;                     // (a + jb) * -j = b - ja
			res.im = -bf_out.re;
		end
		else
		begin
			res = bf_out;
		end
	end

	always_ff @(posedge CLK or posedge RST)
	begin
		if (RST)
		begin
			for (int i = 0; i < dly; i++)
			begin
				line_q[i] <= '0;                    // Clean first block out of reset
			end
			out_s.valid <= 1'b0;
			out_s.last  <= 1'b0;
			out_s.index <= '0;
		end
		else
		begin
			out_s.valid <= in_s.valid;              // One clock, same valid beat
			out_s.last  <= in_s.valid & (&out_idx);
			if (in_s.valid)                         // Everything holds while valid is low
			begin
				for (int i = 0; i < dly - 1; i++)
				begin
					line_q[i] <= line_q[i+1];
				end
				line_q[dly-1] <= fb;
				out_s.index   <= out_idx;
			end
		end
	end

	always_ff @(posedge CLK)
	begin
		if (in_s.valid)
		begin
			out_s.sample <= res;                    // Registered output data
		end
	end

endmodule

// File: sdf_pipeline/twiddle_rotator.sv
`timescale 1ns/1ps

// Registered twiddle multiply between the two radix-2^2 stage pairs
module twiddle_rotator (
	input logic             CLK,
	input logic             RST,
	sample_stream_if.snk    in_s,
	sample_stream_if.src    out_s
);

	logic [fft_pkg::log2_n-1:0]               n3;       // Low index bits, 0..3 within a group
	logic [fft_pkg::log2_n-1:0]               tw_exp;   // Twiddle exponent into tw_rom
	fft_pkg::twiddle_t                        w;        // Selected twiddle
	logic signed [fft_pkg::int_w+fft_pkg::tw_w:0] mul_re;   // Full precision products
	logic signed [fft_pkg::int_w+fft_pkg::tw_w:0] mul_im;

	always_comb
	begin
		n3 = {2'b00, in_s.index[1:0]};
		// Group from index[3:2] gives k1 + 2*k2, exponent is that times n3
		case (in_s.index[3:2])
			2'b00:   tw_exp = '0;               // W0 for the whole first group
			2'b01:   tw_exp = n3 << 1;          // W(0, 2, 4, 6)
			2'b10:   tw_exp = n3;               // W(0, 1, 2, 3)
			default: tw_exp = n3 + (n3 << 1);   // W(0, 3, 6, 9)
		endcase
		w = fft_pkg::tw_rom[tw_exp];
	end

	// (a + jb)(c + jd), with a half LSB added before the Q2.14 drop
	always_comb
	begin
		mul_re = in_s.sample.re * w.re - in_s.sample.im * w.im
			+ (1 <<< (fft_pkg::tw_frac_w - 1));
		mul_im = in_s.sample.re * w.im + in_s.sample.im * w.re
			+ (1 <<< (fft_pkg::tw_frac_w - 1));
	end

	always_ff @(posedge CLK or posedge RST)
	begin
		if (RST)
		begin
			out_s.valid <= 1'b0;
			out_s.last  <= 1'b0;
			out_s.index <= '0;
		end
		else
		begin
			out_s.valid <= in_s.valid;              // Pure one-cycle delay of the stream
			out_s.last  <= in_s.valid & in_s.last;
			if (in_s.valid)
			begin
				out_s.index <= in_s.index;          // No reordering here
			end
		end
	end

	always_ff @(posedge CLK)
	begin
		if (in_s.valid)
		begin
			out_s.sample.re <= mul_re[fft_pkg::tw_frac_w +: fft_pkg::int_w];   // Back to int_w
			out_s.sample.im <= mul_im[fft_pkg::tw_frac_w +: fft_pkg::int_w];
		end
	end

endmodule

// File: tb/fft_asserts.sv
`timescale 1ns/1ps

// Output stream protocol checks for fft_top
module fft_asserts (
	input logic                       CLK,
	input logic                       RST,
	input logic                       valid_o,
	input logic                       last_o,
	input logic [fft_pkg::data_w-1:0] data_re_o,
	input logic [fft_pkg::data_w-1:0] data_im_o
);

	logic [fft_pkg::log2_n:0] beats_q;       // Valid beats since the previous last_o
	logic                     seen_last_q;   // First frame boundary passed

	always_ff @(posedge CLK or posedge RST)
	begin
		if (RST)
		begin
			beats_q     <= '0;
			seen_last_q <= 1'b0;
		end
		else if (valid_o)
		begin
			if (last_o)
			begin
				beats_q     <= '0;
				seen_last_q <= 1'b1;
			end
			else
				beats_q <= beats_q + 1'b1;
		end
	end

	a_reset_quiet: assert property (@(posedge CLK) RST |-> (!valid_o && !last_o))
		else $error("valid_o or last_o high during reset");

	a_last_valid: assert property (@(posedge CLK) disable iff (RST) last_o |-> valid_o)
		else $error("last_o high without valid_o");

	// Exactly 16 beats per frame once the first boundary is known
	a_frame_short: assert property (@(posedge CLK) disable iff (RST)
		(valid_o && last_o && seen_last_q) |-> (beats_q == fft_pkg::n_points - 1))
		else $error("Frame ended before 16 beats");

	a_frame_long: assert property (@(posedge CLK) disable iff (RST)
		(valid_o && seen_last_q && beats_q == fft_pkg::n_points - 1) |-> last_o)
		else $error("Frame ran past 16 beats");

	a_data_known: assert property (@(posedge CLK) disable iff (RST)
		valid_o |-> !$isunknown({data_re_o, data_im_o}))
		else $error("Output data unknown while valid_o is high");

endmodule

bind fft_top fft_asserts i_fft_asserts (
	.CLK       (CLK),
	.RST       (RST),
	.valid_o   (valid_o),
	.last_o    (last_o),
	.data_re_o (data_re_o),
	.data_im_o (data_im_o)
);

// File: tb/fft_tb.sv
`timescale 1ns/1ps

// Testbench for the 16-point SDF FFT
module fft_tb;

	localparam int      seed       = 98;
	localparam int      n_frames   = 10;     // Data frames, the zero flush frame comes on top
	localparam int      max_gap    = 3;      // Longest idle stretch before a sample
	localparam real     tol_lsb    = 2.0;    // Allowed error where twiddles round
	localparam realtime clk_period = 20.0;
	localparam real     two_pi     = 6.283185307179586;
	localparam int      wd_cycles  = (n_frames + 1) * fft_pkg::n_points * (max_gap + 1) + 100;
	localparam realtime wd_time    = wd_cycles * clk_period;   // Worst case with every gap

	logic                       CLK;
	logic                       RST;
	logic                       valid_i;
	logic [fft_pkg::data_w-1:0] data_re_i;
	logic [fft_pkg::data_w-1:0] data_im_i;
	logic                       valid_o;
	logic                       last_o;
	logic [fft_pkg::data_w-1:0] data_re_o;
	logic [fft_pkg::data_w-1:0] data_im_o;

	int  frame_re [n_frames+1][fft_pkg::n_points];   // Input frames, last one is the flush
	int  frame_im [n_frames+1][fft_pkg::n_points];
	real frame_tol [n_frames+1];                     // Per-frame tolerance in output LSB
	int  in_beats;                                   // Valid input samples sent
	int  out_beats;                                  // Valid output samples seen

	fft_top i_fft_top (
		.CLK       (CLK),
		.RST       (RST),
		.valid_i   (valid_i),
		.data_re_i (data_re_i),
		.data_im_i (data_im_i),
		.valid_o   (valid_o),
		.last_o    (last_o),
		.data_re_o (data_re_o),
		.data_im_o (data_im_o)
	);

	initial
	begin
		CLK = 1'b0;
		forever #(clk_period / 2.0) CLK = ~CLK;
	end

	task automatic fail_stop(input string why);
		$display("%s", why);
		$display("=== FAIL ===");
		$fatal(1, "Run stopped");
	endtask

	function automatic int bit_reverse(input int p);
		int r;
		r = 0;
		for (int b = 0; b < fft_pkg::log2_n; b++)
			r = (r << 1) | ((p >> b) & 1);
		return r;
	endfunction

	// Plain DFT bin m of frame k, scaled by 1/16
	task automatic dft_bin(input int k, input int m, output real re, output real im);
		real ang;
		re = 0.0;
		im = 0.0;
		for (int n = 0; n < fft_pkg::n_points; n++)
		begin
			ang = two_pi * real'(m * n) / real'(fft_pkg::n_points);
			re  = re + real'(frame_re[k][n]) * $cos(ang) + real'(frame_im[k][n]) * $sin(ang);
			im  = im + real'(frame_im[k][n]) * $cos(ang) - real'(frame_re[k][n]) * $sin(ang);
		end
		re = re / real'(fft_pkg::n_points);
		im = im / real'(fft_pkg::n_points);
	endtask

	task automatic check_part(input string name, input int k, input int p, input real exp_v,
		input logic [fft_pkg::data_w-1:0] act, input real tol);
		real                        diff;
		int                         exp_int;
		logic [fft_pkg::data_w-1:0] exp_hex;
		diff    = real'($signed(act)) - exp_v;
		exp_int = $rtoi($floor(exp_v + 0.5));
		exp_hex = exp_int[fft_pkg::data_w-1:0];
		if (diff < 0.0)
			diff = -diff;
		assert (diff <= tol + 1.0e-6)
		else
		begin
			$display("[ERROR] %s frame %0d pos %0d: expected %h, got %h", name, k, p, exp_hex, act);
			fail_stop("Output sample outside tolerance");
		end
	endtask

	task automatic build_frames();
		int  tone_bin;
		real ang;
		for (int k = 0; k <= n_frames; k++)
		begin
			frame_tol[k] = tol_lsb;
			for (int n = 0; n < fft_pkg::n_points; n++)
			begin
				frame_re[k][n] = 0;
				frame_im[k][n] = 0;
			end
		end
		frame_re[0][0] = 4656;                     // Impulse 0x1230, divisible by 16
		frame_im[0][0] = -2624;
		frame_tol[0]   = 0.0;
		for (int n = 0; n < fft_pkg::n_points; n++)
		begin
			frame_re[1][n] = 336;                  // Constant, all energy in bin 0
			frame_im[1][n] = -800;
		end
		frame_tol[1] = 0.0;
		tone_bin = int'($urandom % fft_pkg::n_points);
		for (int n = 0; n < fft_pkg::n_points; n++)
		begin
			ang = two_pi * real'(tone_bin * n) / real'(fft_pkg::n_points);
			frame_re[2][n] = $rtoi(6000.0 * $cos(ang));
			frame_im[2][n] = $rtoi(6000.0 * $sin(ang));
		end
		for (int k = 3; k < n_frames; k++)
		begin
			for (int n = 0; n < fft_pkg::n_points; n++)
			begin
				frame_re[k][n] = int'($urandom % 16384) - 8192;   // Headroom for 4 bits of growth
				frame_im[k][n] = int'($urandom % 16384) - 8192;
			end
		end
	endtask

	// Called on a falling edge, returns on the falling edge after the last sample
	task automatic drive_frame(input int k, input bit gapped);
		int gap;
		for (int n = 0; n < fft_pkg::n_points; n++)
		begin
			gap     = gapped ? int'($urandom % (max_gap + 1)) : 0;
			valid_i = 1'b0;
			repeat (gap) @(negedge CLK);
			valid_i   = 1'b1;
			data_re_i = frame_re[k][n][fft_pkg::data_w-1:0];
			data_im_i = frame_im[k][n][fft_pkg::data_w-1:0];
			in_beats++;
			@(negedge CLK);
		end
	endtask

	// Output beat j carries position (j - 15) mod 16 of frame (j - 15) / 16
	always @(negedge CLK)
	begin
		int   k;
		int   p;
		real  exp_re;
		real  exp_im;
		logic exp_last;
		if (!RST && valid_o)
		begin
			exp_last = (out_beats % fft_pkg::n_points) == (fft_pkg::n_points - 2);
			assert (last_o == exp_last)
			else
			begin
				$display("[ERROR] last_o beat %0d: expected %h, got %h", out_beats, exp_last, last_o);
				fail_stop("Frame boundary misplaced");
			end
			if (out_beats >= fft_pkg::n_points - 1)
			begin
				k = (out_beats - (fft_pkg::n_points - 1)) / fft_pkg::n_points;
				p = (out_beats - (fft_pkg::n_points - 1)) % fft_pkg::n_points;
				if (k < n_frames)                  // Flush frame output is not checked
				begin
					dft_bin(k, bit_reverse(p), exp_re, exp_im);
					check_part("data_re_o", k, p, exp_re, data_re_o, frame_tol[k]);
					check_part("data_im_o", k, p, exp_im, data_im_o, frame_tol[k]);
				end
			end
			out_beats++;
		end
	end

	initial
	begin
		void'($urandom(seed));
		RST            = 1'b1;
		valid_i        = 1'b0;
		data_re_i      = '0;
		data_im_i      = '0;
		in_beats       = 0;
		out_beats      = 0;
		build_frames();
		repeat (2) @(posedge CLK);
		@(negedge CLK);
		RST = 1'b0;
		repeat (4)
		begin
			@(negedge CLK);
			assert (!valid_o && !last_o)
			else
			begin
				$display("[ERROR] valid_o, last_o: expected 0, 0, got %h, %h", valid_o, last_o);
				fail_stop("Output active before any input was sent");
			end
		end
		for (int k = 0; k <= n_frames; k++)
			drive_frame(k, k >= 6 && k < n_frames);   // Later frames stall at random
		valid_i   = 1'b0;
		data_re_i = '0;
		data_im_i = '0;
		wait (out_beats == in_beats);
		repeat (2) @(negedge CLK);
		if (out_beats == in_beats)
		begin
			$display("=== PASS ===");
			$finish;
		end
		else
			fail_stop("More output samples came out than input samples went in");
	end

	initial
	begin
		#(wd_time);
		fail_stop("Timeout, the run did not finish in time");
	end

endmodule
